/* hw/fifo_ptr_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Pointer and end-of-packet status between the two FIFO controllers
interface fifo_ptr_if #(
	parameter int LGFLEN = netfifo_pkg::DEFAULT_LGFLEN
);

	// Write pointer, one extra bit for wrap
	logic [LGFLEN:0] wr_ptr;
	// Read pointer, same width
	logic [LGFLEN:0] rd_ptr;
	// Slot of the most recent last word
	logic [LGFLEN:0] eop_ptr;
	// A complete packet is still buffered
	logic eop_valid;
	// Output word accepted this cycle
	logic rd_take;

	// Write control owns wr_ptr and the EOP marker
	modport writer (
		output wr_ptr, eop_ptr, eop_valid,
		input rd_ptr, rd_take
	);

	// Read control only needs the write pointer for empty
	modport reader (
		input wr_ptr,
		output rd_ptr, rd_take
	);

endinterface

`default_nettype wire

/* hw/mem_wr_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Buffer memory write port
interface mem_wr_if #(
	parameter int BW = netfifo_pkg::DEFAULT_BW,
	parameter int LGFLEN = netfifo_pkg::DEFAULT_LGFLEN
);

	// Write strobe, low during abort
	logic wr_en;
	// Memory slot, pointer without wrap bit
	logic [LGFLEN-1:0] wr_idx;
	// Payload and end-of-packet flag
	logic [BW-1:0] wr_data;
	logic wr_last;

	modport writer (output wr_en, wr_idx, wr_data, wr_last);

	modport memory (input wr_en, wr_idx, wr_data, wr_last);

endinterface

`default_nettype wire

/* hw/netfifo.sv */
`timescale 1ns/10ps
`default_nettype none

module netfifo #(
	parameter int BW = netfifo_pkg::DEFAULT_BW,
	parameter int LGFLEN = netfifo_pkg::DEFAULT_LGFLEN
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Input stream
	input logic s_axin_valid,
	output logic s_axin_ready,
	input logic [BW-1:0] s_axin_data,
	input logic s_axin_last,
	input logic s_axin_abort,
	// Output stream
	output logic m_axin_valid,
	input logic m_axin_ready,
	output logic [BW-1:0] m_axin_data,
	output logic m_axin_last,
	output logic m_axin_abort
);

	// Write side abort the reader must forward
	logic abort_req;

	//////////////////////////////////////////////////////////////////////
	// Internal buses
	//////////////////////////////////////////////////////////////////////

	fifo_ptr_if #(.LGFLEN(LGFLEN)) ptr_bus ();

	mem_wr_if #(.BW(BW), .LGFLEN(LGFLEN)) mem_bus ();

	//////////////////////////////////////////////////////////////////////
	// Controllers and storage
	//////////////////////////////////////////////////////////////////////

	// Accepts words, tracks packet ends, rewinds on abort
	pkt_write_ctrl #(
		.BW(BW),
		.LGFLEN(LGFLEN)
	) u_write (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.s_axin_valid(s_axin_valid),
		.s_axin_data(s_axin_data),
		.s_axin_last(s_axin_last),
		.s_axin_abort(s_axin_abort),
		.m_axin_valid(m_axin_valid),
		.s_axin_ready(s_axin_ready),
		.abort_req(abort_req),
		.ptr(ptr_bus.writer),
		.mem(mem_bus.writer)
	);

	// Presents the head word and the output abort
	pkt_read_ctrl #(
		.LGFLEN(LGFLEN)
	) u_read (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.m_axin_ready(m_axin_ready),
		.s_axin_abort(s_axin_abort),
		.abort_req(abort_req),
		.rd_last(m_axin_last),
		.m_axin_valid(m_axin_valid),
		.m_axin_abort(m_axin_abort),
		.ptr(ptr_bus.reader)
	);

	// Head slot addressed by the read pointer
	pkt_buffer_mem #(
		.BW(BW),
		.LGFLEN(LGFLEN)
	) u_mem (
		.S_AXI_ACLK(S_AXI_ACLK),
		.wr(mem_bus.memory),
		.rd_idx(ptr_bus.rd_ptr[LGFLEN-1:0]),
		.rd_data(m_axin_data),
		.rd_last(m_axin_last)
	);

endmodule

`default_nettype wire

/* hw/netfifo_pkg.sv */
`default_nettype none

// Widths and state encodings shared by the packet FIFO blocks
package netfifo_pkg;

	//////////////////////////////////////////////////////////////////////
	// Default sizes
	//////////////////////////////////////////////////////////////////////

	// Stream data word width in bits
	localparam int DEFAULT_BW = 8;

	// Log2 of FIFO depth in words
	localparam int DEFAULT_LGFLEN = 4;

	//////////////////////////////////////////////////////////////////////
	// State encodings
	//////////////////////////////////////////////////////////////////////

	// Write side packet position
	typedef enum logic {
		WR_IDLE,	// Between packets
		WR_MID		// Unfinished packet being accepted
	} wr_state_t;

	// Read side packet position
	typedef enum logic [1:0] {
		// At a packet boundary
		RD_IDLE,
		// Words of a packet presented or taken
		RD_MID,
		// Output abort held until accepted
		RD_ABORT
	} rd_state_t;

endpackage

`default_nettype wire

/* hw/pkt_buffer_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module pkt_buffer_mem #(
	parameter int BW = netfifo_pkg::DEFAULT_BW,
	parameter int LGFLEN = netfifo_pkg::DEFAULT_LGFLEN
) (
	input logic S_AXI_ACLK,
	mem_wr_if.memory wr,
	// Head slot, read pointer without wrap bit
	input logic [LGFLEN-1:0] rd_idx,
	output logic [BW-1:0] rd_data,
	output logic rd_last
);

	localparam int DEPTH = 1 << LGFLEN;

	// Last flag on top of the data word
	logic [BW:0] words [0:DEPTH-1];

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr.wr_en)
			words[wr.wr_idx] <= {wr.wr_last, wr.wr_data};
	end

	// Head word straight out, no read register
	assign {rd_last, rd_data} = words[rd_idx];

endmodule

`default_nettype wire

/* hw/pkt_read_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module pkt_read_ctrl #(
	parameter int LGFLEN = netfifo_pkg::DEFAULT_LGFLEN
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Sink accepts the head word
	input logic m_axin_ready,
	// Raw input abort
	input logic s_axin_abort,
	// Abort of a packet the reader may have started
	input logic abort_req,
	// Last flag of the head word
	input logic rd_last,
	output logic m_axin_valid,
	output logic m_axin_abort,
	fifo_ptr_if.reader ptr
);
	import netfifo_pkg::*;

	logic [LGFLEN:0] rd_ptr;
	rd_state_t rd_state;
	logic rd_take;

	// Head word visible whenever the pointers differ
	assign m_axin_valid = (ptr.wr_ptr != rd_ptr);
	assign rd_take = m_axin_valid && m_axin_ready;
	assign m_axin_abort = (rd_state == RD_ABORT);

	assign ptr.rd_ptr = rd_ptr;
	assign ptr.rd_take = rd_take;

	// Read pointer
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_ptr <= '0;
		else if (rd_take)
			rd_ptr <= rd_ptr + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Output packet FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_state <= RD_IDLE;
		else
		begin
			case (rd_state)
			RD_ABORT:
				// Taken by the sink, or nothing left to show
				if (!m_axin_valid || m_axin_ready)
					rd_state <= RD_IDLE;
			default:
				// Sink saw part of a dropped packet
				if (abort_req && (m_axin_valid || (rd_state == RD_MID)))
					rd_state <= RD_ABORT;
				// Stalled or non-last word means inside a packet
				else if (m_axin_valid)
					rd_state <= (!m_axin_ready || !rd_last) ? RD_MID : RD_IDLE;
			endcase
		end
	end

	// Stalled head word stays visible and unchanged, even across a rewind
	stalled_word_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(m_axin_valid && !m_axin_ready) |=> (m_axin_valid && $stable(rd_last)));

	// Output abort is always caused by an input abort one edge back
	abort_from_input: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN)
		$rose(m_axin_abort) |-> $past(s_axin_abort));

endmodule

`default_nettype wire

/* hw/pkt_write_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module pkt_write_ctrl #(
	parameter int BW = netfifo_pkg::DEFAULT_BW,
	parameter int LGFLEN = netfifo_pkg::DEFAULT_LGFLEN
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Input stream from the source
	input logic s_axin_valid,
	input logic [BW-1:0] s_axin_data,
	input logic s_axin_last,
	input logic s_axin_abort,
	// Output side currently shows a word
	input logic m_axin_valid,
	output logic s_axin_ready,
	// Abort the reader has to pass on
	output logic abort_req,
	fifo_ptr_if.writer ptr,
	mem_wr_if.writer mem
);
	import netfifo_pkg::*;

	// Fill value at which the memory is full
	localparam logic [LGFLEN:0] FULL_FILL = (LGFLEN+1)'(1 << LGFLEN);

	logic [LGFLEN:0] wr_ptr;
	logic [LGFLEN:0] eop_ptr;
	logic eop_valid;
	wr_state_t wr_state;
	logic [LGFLEN:0] fill;
	logic full;
	logic w_wr;
	logic s_abort;

	//////////////////////////////////////////////////////////////////////
	// Flow control
	//////////////////////////////////////////////////////////////////////

	// Words held, wrap bit makes this exact
	assign fill = wr_ptr - ptr.rd_ptr;
	assign full = fill[LGFLEN];
	// Abort is always taken
	assign s_axin_ready = s_axin_abort || !full;
	// Accepted word, never on an abort cycle
	assign w_wr = s_axin_valid && s_axin_ready && !s_axin_abort;
	// Only an abort inside a packet counts
	assign s_abort = s_axin_abort && (wr_state == WR_MID);
	// Nothing complete to fall back on
	assign abort_req = s_abort && !eop_valid;

	// Packet position on the input
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_state <= WR_IDLE;
		else if (s_axin_abort)
			wr_state <= WR_IDLE;
		else if (w_wr)
			wr_state <= s_axin_last ? WR_IDLE : WR_MID;
	end

	//////////////////////////////////////////////////////////////////////
	// End of packet marker
	//////////////////////////////////////////////////////////////////////

	// Written word shows up one edge later, so a fresh last word
	// is always still buffered when the marker is set
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			eop_ptr <= '0;
			eop_valid <= 1'b0;
		end
		else if (w_wr && s_axin_last)
		begin
			eop_ptr <= wr_ptr;
			eop_valid <= 1'b1;
		end
		else if (ptr.rd_take && (ptr.rd_ptr == eop_ptr))
			eop_valid <= 1'b0;
	end

	// Write pointer with abort rewind
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_ptr <= '0;
		else if (s_abort)
		begin
			// Back to just past the last complete packet
			if (eop_valid)
				wr_ptr <= eop_ptr + 1'b1;
			// Head word stays for the output abort
			else if (m_axin_valid)
				wr_ptr <= ptr.rd_ptr + 1'b1;
		end
		else if (w_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	assign ptr.wr_ptr = wr_ptr;
	assign ptr.eop_ptr = eop_ptr;
	assign ptr.eop_valid = eop_valid;

	// Memory port
	assign mem.wr_en = w_wr;
	assign mem.wr_idx = wr_ptr[LGFLEN-1:0];
	assign mem.wr_data = s_axin_data;
	assign mem.wr_last = s_axin_last;

	// Reader and writer together never overrun the depth
	fill_in_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		fill <= FULL_FILL);

	// Abort between packets leaves the buffer alone
	idle_abort_no_move: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN)
		(s_axin_abort && (wr_state == WR_IDLE)) |=> $stable(wr_ptr));

endmodule

`default_nettype wire

/* netfifo.f */
hw/netfifo_pkg.sv
hw/fifo_ptr_if.sv
hw/mem_wr_if.sv
hw/pkt_buffer_mem.sv
hw/pkt_write_ctrl.sv
hw/pkt_read_ctrl.sv
hw/netfifo.sv
verification/netfifo_tb.sv

/* verification/netfifo_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module netfifo_tb;

	localparam int BW = 8;
	localparam int LGFLEN = 4;
	localparam int DEPTH = 1 << LGFLEN;

	// Clock, reset and DUT inputs start in a known state
	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN = 1'b0;
	logic s_axin_valid = 1'b0;
	logic [BW-1:0] s_axin_data = '0;
	logic s_axin_last = 1'b0;
	logic s_axin_abort = 1'b0;
	logic m_axin_ready = 1'b0;
	logic s_axin_ready;
	logic m_axin_valid;
	logic [BW-1:0] m_axin_data;
	logic m_axin_last;
	logic m_axin_abort;

	// Test table, one packet per entry
	string t_name[$];
	int t_len[$], t_abort[$], t_mode[$], t_idle[$], t_exp[$];

	// Reference model queues, last flag above the data
	logic [BW:0] src_cur[$];
	logic [BW:0] sink_cur[$];
	logic [BW:0] exp_q[$];
	string exp_name[$];
	string cur_name;
	int data_errs = 0;
	int other_errs = 0;
	int fill, cyc, k, n, mode, ab_pos, aborts_seen, limit;
	int unsigned seed_val;
	logic [BW-1:0] cur_data;
	logic in_acc = 1'b0;
	logic abort_due = 1'b0;
	logic abort_hold = 1'b0;
	logic check_fill = 1'b0;
	logic table_ready = 1'b0;

	netfifo #(.BW(BW), .LGFLEN(LGFLEN)) i_dut (.*);

	initial
	begin
		forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	task automatic add_test(input string name, input int len, input int ab, input int md,
		input int idl, input int ex);
		t_name.push_back(name);
		t_len.push_back(len);
		t_abort.push_back(ab);
		t_mode.push_back(md);
		t_idle.push_back(idl);
		t_exp.push_back(ex);
	endtask

	// Mode 0 always ready, 1 stalled for 20 cycles, 2 random
	function automatic logic sink_ready(input int md, input int c);
		if (md == 1)
			return c >= 20;
		if (md == 2)
			return ($urandom % 4) != 0;
		return 1'b1;
	endfunction

	// Completed output packet against the oldest expected words
	task automatic check_packet();
		logic [BW:0] want;
		string nm;
		assert (exp_q.size() >= sink_cur.size())
		else
		begin
			other_errs++;
			$display("Extra output packet of %0d words with no input packet", sink_cur.size());
		end
		foreach (sink_cur[i])
		begin
			if (exp_q.size() > 0)
			begin
				want = exp_q.pop_front();
				nm = exp_name.pop_front();
				assert (sink_cur[i] === want)
				else
				begin
					data_errs++;
					$display("[ERROR] %s word %0d: expected last %0b data %h, actual last %0b data %h",
						nm, i, want[BW], want[BW-1:0], sink_cur[i][BW], sink_cur[i][BW-1:0]);
				end
			end
		end
		sink_cur.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// One clock cycle, sampled at the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(negedge S_AXI_ACLK);
		if (abort_due)
			assert (m_axin_abort === 1'b1)
			else
			begin
				other_errs++;
				$display("Output abort did not rise after the input abort in %s", cur_name);
			end
		// Unaccepted output abort has to stay
		if (abort_hold)
			assert (m_axin_abort === 1'b1)
			else
			begin
				other_errs++;
				$display("Output abort dropped before the sink took it in %s", cur_name);
			end
		if (check_fill)
			assert (s_axin_ready === (fill < DEPTH))
			else
			begin
				other_errs++;
				$display("[ERROR] %s: s_axin_ready expected %0b actual %0b",
					cur_name, fill < DEPTH, s_axin_ready);
			end
		abort_due = 1'b0;
		abort_hold = m_axin_abort && m_axin_valid && !m_axin_ready;
		in_acc = s_axin_valid && s_axin_ready && !s_axin_abort;
		// Input abort drops the unfinished packet, no-op between packets
		if (s_axin_abort)
			src_cur.delete();
		else if (in_acc)
		begin
			src_cur.push_back({s_axin_last, s_axin_data});
			if (s_axin_last)
			begin
				foreach (src_cur[i])
				begin
					exp_q.push_back(src_cur[i]);
					exp_name.push_back(cur_name);
				end
				src_cur.delete();
			end
		end
		// Output abort throws away what the sink gathered of the packet
		if (m_axin_abort)
		begin
			aborts_seen++;
			sink_cur.delete();
		end
		else if (m_axin_valid && m_axin_ready)
		begin
			sink_cur.push_back({m_axin_last, m_axin_data});
			if (m_axin_last)
				check_packet();
		end
		if (in_acc)
			fill++;
		if (m_axin_valid && m_axin_ready)
			fill--;
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	initial
	begin
		seed_val = $urandom(31082);
		for (n = 1; n <= 10; n++)
			add_test($sformatf("len_%0d", n), n, -1, 0, 2, 0);
		add_test("fill_stall", 20, -1, 1, 20, 0);
		add_test("keep_complete", 3, -1, 1, 0, 0);
		add_test("drop_partial", 5, 2, 1, 25, 0);
		add_test("after_drop", 4, -1, 0, 2, 0);
		add_test("abort_stalled", 6, 3, 1, 25, 1);
		add_test("abort_streaming", 6, 3, 0, 2, 1);
		add_test("after_abort", 5, -1, 0, 2, 0);
		for (n = 0; n < 12; n++)
		begin
			k = 1 + $urandom % 12;
			if (k > 1 && $urandom % 4 == 0)
				ab_pos = 1 + $urandom % (k - 1);
			else
				ab_pos = -1;
			add_test($sformatf("random_%0d", n), k, ab_pos, 2, $urandom % 4, 2);
		end
		// Watchdog budget from the table size
		limit = 1000;
		foreach (t_len[i])
			limit += 4 * t_len[i];
		table_ready = 1'b1;
		repeat (16) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		assert (m_axin_valid === 1'b0 && m_axin_abort === 1'b0 && s_axin_ready === 1'b1)
		else
		begin
			other_errs++;
			$display("Stream outputs not idle after reset");
		end

		//////////////////////////////////////////////////////////////////////
		// Table loop
		//////////////////////////////////////////////////////////////////////

		for (n = 0; n < t_name.size(); n++)
		begin
			cur_name = t_name[n];
			mode = t_mode[n];
			check_fill = (mode == 1) && (t_abort[n] < 0);
			fill = 0;
			aborts_seen = 0;
			k = 0;
			cyc = 0;
			cur_data = BW'($urandom);
			while (k < t_len[n])
			begin
				m_axin_ready = sink_ready(mode, cyc);
				cyc++;
				if (k == t_abort[n])
				begin
					// Abort strobe ends the packet
					s_axin_valid = 1'b0;
					s_axin_abort = 1'b1;
					tick();
					s_axin_abort = 1'b0;
					abort_due = (t_exp[n] == 1);
					break;
				end
				s_axin_valid = 1'b1;
				s_axin_data = cur_data;
				s_axin_last = (k == t_len[n] - 1);
				tick();
				if (in_acc)
				begin
					k++;
					cur_data = BW'($urandom);
				end
			end
			s_axin_valid = 1'b0;
			repeat (t_idle[n])
			begin
				m_axin_ready = sink_ready(mode, cyc);
				cyc++;
				tick();
			end
			if (t_exp[n] != 2)
				assert ((aborts_seen > 0) == (t_exp[n] == 1))
				else
				begin
					other_errs++;
					$display("[ERROR] %s: output abort expected %0d actual %0d",
						cur_name, t_exp[n], aborts_seen > 0);
				end
		end
		check_fill = 1'b0;
		m_axin_ready = 1'b1;
		repeat (2 * DEPTH)
			tick();
		assert (exp_q.size() == 0 && sink_cur.size() == 0)
		else
		begin
			other_errs++;
			$display("Missing packets, %0d expected words never came out", exp_q.size());
		end
		$display("Errors: %0d data, %0d other", data_errs, other_errs);
		if (data_errs + other_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		wait (table_ready);
		repeat (limit) @(posedge S_AXI_ACLK);
		$display("Timeout, run still busy after %0d cycles", limit);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
